/* common/exe_pkg.sv */
package exe_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or,  alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs,
        src1_sa,    // imm[10:6]
        src1_pc
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_simm,
        src2_zimm,
        src2_8      // link address offset
    } src2_sel_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw,
        mem_sb, mem_sh, mem_sw
    } mem_op_e;

    typedef enum logic [2:0] {
        hilo_none,
        hilo_mult, hilo_multu,
        hilo_mthi, hilo_mtlo,
        hilo_mfhi, hilo_mflo
    } hilo_op_e;

    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12
    } exccode_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_e;

    // decoded instruction entering execute
    typedef struct packed {
        alu_op_e     alu_op;
        src1_sel_e   src1_sel;
        src2_sel_e   src2_sel;
        logic        ov_en;     // add, sub, addi
        mem_op_e     mem_op;
        hilo_op_e    hilo_op;
        logic        gr_we;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] pc;
    } exe_op_t;

    typedef struct packed {
        logic        ex;
        exccode_e    exccode;
        mem_op_e     mem_op;
        logic [31:0] mem_addr;
        size_e       mem_size;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] result;
        logic [31:0] pc;
    } exe_res_t;

    function automatic logic mem_is_store(mem_op_e op);
        return op inside {mem_sb, mem_sh, mem_sw};
    endfunction

endpackage

/* design/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     allowin,
    input  logic     ready_go,
    input  logic     next_allowin,
    output logic     valid,
    output payload_t payload
);

    // empty, or the current item leaves this cycle
    assign allowin = !valid || (ready_go && next_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            payload <= in_payload;
        end
    end

endmodule

/* alu/exe_alu.sv */
`timescale 1ns/1ps

module exe_alu
    import exe_pkg::*;
(
    input  exe_op_t     op,
    output logic [31:0] src1,
    output logic [31:0] src2,
    output logic [31:0] alu_result,
    output logic        overflow
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        add_ov;
    logic        sub_ov;

    always_comb begin
        case (op.src1_sel)
            src1_sa: src1 = {27'd0, op.imm[10:6]};
            src1_pc: src1 = op.pc;
            default: src1 = op.rs_value;
        endcase
    end

    always_comb begin
        case (op.src2_sel)
            src2_simm: src2 = {{16{op.imm[15]}}, op.imm};
            src2_zimm: src2 = {16'd0, op.imm};
            src2_8:    src2 = 32'd8;
            default:   src2 = op.rt_value;
        endcase
    end

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // operand signs agree but result sign differs
    assign add_ov = (src1[31] == src2[31]) && (sum[31] != src1[31]);
    assign sub_ov = (src1[31] != src2[31]) && (diff[31] != src1[31]);

    always_comb begin
        case (op.alu_op)
            alu_add:  alu_result = sum;
            alu_sub:  alu_result = diff;
            alu_slt:  alu_result = {31'd0, $signed(src1) < $signed(src2)};
            alu_sltu: alu_result = {31'd0, src1 < src2};
            alu_and:  alu_result = src1 & src2;
            alu_nor:  alu_result = ~(src1 | src2);
            alu_or:   alu_result = src1 | src2;
            alu_xor:  alu_result = src1 ^ src2;
            alu_sll:  alu_result = src2 << src1[4:0];
            alu_srl:  alu_result = src2 >> src1[4:0];
            alu_sra:  alu_result = $unsigned($signed(src2) >>> src1[4:0]);
            alu_lui:  alu_result = {src2[15:0], 16'd0};
            default:  alu_result = 32'd0;
        endcase
    end

    assign overflow = op.ov_en &&
                      ((op.alu_op == alu_add && add_ov) ||
                       (op.alu_op == alu_sub && sub_ov));

endmodule

/* design/hilo_unit.sv */
`timescale 1ns/1ps

module hilo_unit
    import exe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  hilo_op_e    hilo_op,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    input  logic        write_en,
    output logic [31:0] rdata
);

    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] mul_a;
    logic [63:0] mul_b;
    logic [63:0] product;

    // sign fill only for mult, low 64 bits of the product stay exact
    assign mul_a   = {{32{(hilo_op == hilo_mult) & src1[31]}}, src1};
    assign mul_b   = {{32{(hilo_op == hilo_mult) & src2[31]}}, src2};
    assign product = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= 32'd0;
            lo <= 32'd0;
        end else if (write_en) begin
            case (hilo_op)
                hilo_mult, hilo_multu: begin
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
                hilo_mthi: hi <= src1;
                hilo_mtlo: lo <= src1;
                default: ;
            endcase
        end
    end

    assign rdata = (hilo_op == hilo_mfhi) ? hi : lo;

endmodule

/* design/mem_req_gen.sv */
`timescale 1ns/1ps

module mem_req_gen
    import exe_pkg::*;
(
    input  mem_op_e     mem_op,
    input  logic [31:0] addr,
    input  logic [31:0] rt_value,
    output size_e       size,
    output logic [3:0]  wstrb,
    output logic [31:0] wdata,
    output logic        adel,
    output logic        ades
);

    logic [1:0] low;

    assign low = addr[1:0];

    always_comb begin
        case (mem_op)
            mem_lb, mem_lbu, mem_sb: size = size_byte;
            mem_lh, mem_lhu, mem_sh: size = size_half;
            default:                 size = size_word;
        endcase
    end

    always_comb begin
        wstrb = 4'b0000;    // loads write nothing
        wdata = rt_value;
        case (mem_op)
            mem_sb: begin
                wstrb = 4'b0001 << low;
                wdata = {4{rt_value[7:0]}};
            end
            mem_sh: begin
                wstrb = low[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            mem_sw: begin
                wstrb = 4'b1111;
            end
            default: ;
        endcase
    end

    // halfwords need bit 0 clear, words both bits
    always_comb begin
        adel = 1'b0;
        ades = 1'b0;
        case (mem_op)
            mem_lh, mem_lhu: adel = low[0];
            mem_lw:          adel = |low;
            mem_sh:          ades = low[0];
            mem_sw:          ades = |low;
            default: ;
        endcase
    end

endmodule

/* design/exe_top.sv */
`timescale 1ns/1ps

module exe_top
    import exe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  exe_op_t     in_op,
    output logic        out_valid,
    input  logic        out_ready,
    output exe_res_t    out_res,
    output logic        data_req,
    output logic        data_wr,
    output size_e       data_size,
    output logic [31:0] data_addr,
    output logic [3:0]  data_wstrb,
    output logic [31:0] data_wdata,
    input  logic        data_addr_ok
);

    logic        s1_valid;
    exe_op_t     s1_op;
    exe_res_t    s1_res;
    logic        s1_ex;
    exccode_e    s1_exccode;
    logic        s2_allowin;
    logic        s2_valid;
    logic        s2_ready_go;
    logic        s2_mem_access;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;
    logic        overflow;
    logic        hilo_we;
    logic [31:0] hilo_rdata;
    size_e       mem_size;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        adel;
    logic        ades;

    stage_reg #(.payload_t(exe_op_t)) s1 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_payload   (in_op),
        .allowin      (in_ready),
        .ready_go     (1'b1),       // single cycle stage
        .next_allowin (s2_allowin),
        .valid        (s1_valid),
        .payload      (s1_op)
    );

    exe_alu u_alu (
        .op         (s1_op),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .overflow   (overflow)
    );

    // commit on the s1 -> s2 move so a later mfhi/mflo sees it
    assign hilo_we = s1_valid && s2_allowin && !s1_ex;

    hilo_unit u_hilo (
        .clk      (clk),
        .reset    (reset),
        .hilo_op  (s1_op.hilo_op),
        .src1     (src1),
        .src2     (src2),
        .write_en (hilo_we),
        .rdata    (hilo_rdata)
    );

    mem_req_gen u_mem_req (
        .mem_op   (s1_op.mem_op),
        .addr     (alu_result),
        .rt_value (s1_op.rt_value),
        .size     (mem_size),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .adel     (adel),
        .ades     (ades)
    );

    assign s1_ex      = overflow || adel || ades;
    assign s1_exccode = overflow ? exc_ov :
                        adel     ? exc_adel :
                        ades     ? exc_ades : exc_none;

    always_comb begin
        s1_res.ex       = s1_ex;
        s1_res.exccode  = s1_exccode;
        s1_res.mem_op   = s1_op.mem_op;
        s1_res.mem_addr = alu_result;
        s1_res.mem_size = mem_size;
        s1_res.wstrb    = wstrb;
        s1_res.wdata    = wdata;
        s1_res.gr_we    = s1_op.gr_we;
        s1_res.dest     = s1_op.dest;
        s1_res.result   = (s1_op.hilo_op inside {hilo_mfhi, hilo_mflo}) ? hilo_rdata
                                                                        : alu_result;
        s1_res.pc       = s1_op.pc;
    end

    stage_reg #(.payload_t(exe_res_t)) s2 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (s1_valid),
        .in_payload   (s1_res),
        .allowin      (s2_allowin),
        .ready_go     (s2_ready_go),
        .next_allowin (out_ready),
        .valid        (s2_valid),
        .payload      (out_res)
    );

    // faulting accesses never reach memory
    assign s2_mem_access = (out_res.mem_op != mem_none) && !out_res.ex;
    assign s2_ready_go   = s2_mem_access ? data_addr_ok : 1'b1;
    assign out_valid     = s2_valid && s2_ready_go;

    assign data_req   = s2_valid && s2_mem_access && out_ready;
    assign data_wr    = mem_is_store(out_res.mem_op);
    assign data_size  = out_res.mem_size;
    assign data_addr  = out_res.mem_addr;
    assign data_wstrb = out_res.wstrb;
    assign data_wdata = out_res.wdata;

endmodule

/* verif/exe_model.svh */
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

logic [31:0] model_hi = '0;
logic [31:0] model_lo = '0;
exe_res_t    expected_q[$];    // program order

function automatic logic [31:0] model_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] ext;
    ext = {{32{b[31]}}, b} >> a[4:0];    // arithmetic shift via sign fill
    case (op)
        alu_add:  return a + b;
        alu_sub:  return a - b;
        alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        alu_and:  return a & b;
        alu_nor:  return ~(a | b);
        alu_or:   return a | b;
        alu_xor:  return a ^ b;
        alu_sll:  return b << a[4:0];
        alu_srl:  return b >> a[4:0];
        alu_sra:  return ext[31:0];
        alu_lui:  return {b[15:0], 16'h0000};
        default:  return 32'd0;
    endcase
endfunction

function automatic logic model_overflow(exe_op_t op, logic [31:0] a, logic [31:0] b);
    logic [32:0] wide;
    if (!op.ov_en || !(op.alu_op inside {alu_add, alu_sub})) return 1'b0;
    if (op.alu_op == alu_add) wide = {a[31], a} + {b[31], b};
    else wide = {a[31], a} - {b[31], b};
    return wide[32] != wide[31];
endfunction

task automatic model_accept(input exe_op_t op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [63:0] prod;
    logic [1:0]  low;
    exe_res_t    res;
    a = (op.src1_sel == src1_pc) ? op.pc :
        (op.src1_sel == src1_sa) ? {27'd0, op.imm[10:6]} : op.rs_value;
    case (op.src2_sel)
        src2_simm: b = {{16{op.imm[15]}}, op.imm};
        src2_zimm: b = {16'd0, op.imm};
        src2_8:    b = 32'd8;
        default:   b = op.rt_value;
    endcase
    r = model_alu(op.alu_op, a, b);
    low = r[1:0];
    res = '0;
    res.mem_op = op.mem_op;
    res.mem_addr = r;
    res.gr_we = op.gr_we;
    res.dest = op.dest;
    res.pc = op.pc;
    res.result = r;
    case (op.mem_op)
        mem_lb, mem_lbu: res.mem_size = size_byte;
        mem_lh, mem_lhu: res.mem_size = size_half;
        mem_sb: begin
            res.mem_size = size_byte;
            res.wstrb[low] = 1'b1;
            res.wdata = {4{op.rt_value[7:0]}};
        end
        mem_sh: begin
            res.mem_size = size_half;
            res.wstrb = low[1] ? 4'b1100 : 4'b0011;
            res.wdata = {2{op.rt_value[15:0]}};
        end
        mem_sw: begin
            res.mem_size = size_word;
            res.wstrb = 4'b1111;
            res.wdata = op.rt_value;
        end
        default: res.mem_size = size_word;
    endcase
    res.ex = 1'b1;
    if (model_overflow(op, a, b)) res.exccode = exc_ov;
    else if ((op.mem_op inside {mem_lh, mem_lhu} && low[0]) || (op.mem_op == mem_lw && low != 0))
        res.exccode = exc_adel;
    else if ((op.mem_op == mem_sh && low[0]) || (op.mem_op == mem_sw && low != 0))
        res.exccode = exc_ades;
    else res.ex = 1'b0;
    if (op.hilo_op == hilo_mfhi) res.result = model_hi;
    if (op.hilo_op == hilo_mflo) res.result = model_lo;
    if (!res.ex) begin
        if (op.hilo_op == hilo_mult) prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        else prod = {32'd0, a} * {32'd0, b};
        case (op.hilo_op)
            hilo_mult, hilo_multu: {model_hi, model_lo} = prod;
            hilo_mthi: model_hi = a;
            hilo_mtlo: model_lo = a;
            default: ;
        endcase
    end
    expected_q.push_back(res);
endtask

`endif

/* verif/exe_tb.sv */
`timescale 1ns/1ps

module exe_tb
    import exe_pkg::*;
();

    localparam int num_items = 2000;
    localparam int cycles_per_item = 20;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    exe_op_t     in_op;
    logic        out_valid;
    logic        out_ready;
    exe_res_t    out_res;
    logic        data_req;
    logic        data_wr;
    size_e       data_size;
    logic [31:0] data_addr;
    logic [3:0]  data_wstrb;
    logic [31:0] data_wdata;
    logic        data_addr_ok;
    logic        in_fire = 1'b0;
    int unsigned sent = 0;
    int unsigned received = 0;
    int unsigned mem_accepts = 0;
    int unsigned mem_expected = 0;

    `include "exe_model.svh"

    exe_top u_exe_top (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("%0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [31:0] pick_word();
        case ($urandom_range(0, 7))
            0: return 32'h7fff_ffff;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    function automatic exe_op_t random_op();
        exe_op_t op;
        op = '0;
        op.alu_op = alu_op_e'(4'($urandom_range(0, 11)));
        op.src1_sel = src1_sel_e'(2'($urandom_range(0, 2)));
        op.src2_sel = src2_sel_e'(2'($urandom_range(0, 3)));
        op.gr_we = 1'($urandom);
        op.dest = 5'($urandom);
        op.imm = 16'(pick_word());
        op.rs_value = pick_word();
        op.rt_value = pick_word();
        op.pc = {30'($urandom), 2'b00};
        case ($urandom_range(0, 9))
            0, 1: begin
                op.hilo_op = hilo_op_e'(3'($urandom_range(1, 6)));
                op.src1_sel = src1_rs;
                op.src2_sel = src2_rt;
            end
            2, 3, 4: begin
                op.mem_op = mem_op_e'(4'($urandom_range(1, 8)));
                op.alu_op = alu_add;
                op.src1_sel = src1_rs;
                op.src2_sel = src2_simm;
                op.imm[1:0] = 2'b00;
                op.rs_value[1:0] = ($urandom_range(0, 1) == 0) ? 2'b00 : 2'($urandom);
            end
            default: ;
        endcase
        op.ov_en = (op.alu_op inside {alu_add, alu_sub}) && ($urandom_range(0, 1) == 1);
        return op;
    endfunction

    task automatic drive_inputs();
        if (!in_valid || in_fire) begin    // hold an item until accepted
            in_valid = (sent < num_items) && ($urandom_range(0, 3) != 0);
            if (in_valid) in_op = random_op();
        end
        out_ready = ($urandom_range(0, 9) < 7);
        data_addr_ok = ($urandom_range(0, 9) < 7);
    endtask

    task automatic compare_output();
        exe_res_t exp;
        logic     mem_access;
        if (expected_q.size() == 0) begin
            stop_with_error("output transfer with no item outstanding");
        end else begin
            exp = expected_q.pop_front();
            mem_access = (exp.mem_op != mem_none) && !exp.ex;
            check_value("pc", out_res.pc, exp.pc);
            check_value("ex", 32'(out_res.ex), 32'(exp.ex));
            check_value("exccode", 32'(out_res.exccode), 32'(exp.exccode));
            check_value("gr_we", 32'(out_res.gr_we), 32'(exp.gr_we));
            check_value("dest", 32'(out_res.dest), 32'(exp.dest));
            check_value("result", out_res.result, exp.result);
            check_value("mem_op", 32'(out_res.mem_op), 32'(exp.mem_op));
            check_value("data_req", 32'(data_req), 32'(mem_access));
            if (exp.mem_op != mem_none) begin
                check_value("mem_addr", out_res.mem_addr, exp.mem_addr);
                check_value("mem_size", 32'(out_res.mem_size), 32'(exp.mem_size));
                check_value("wstrb", 32'(out_res.wstrb), 32'(exp.wstrb));
                if (exp.wstrb != 4'b0000) check_value("wdata", out_res.wdata, exp.wdata);
            end
            if (mem_access) begin
                mem_expected++;
                check_value("data_wr", 32'(data_wr), 32'(exp.wstrb != 4'b0000));
                check_value("data_size", 32'(data_size), 32'(exp.mem_size));
                check_value("data_addr", data_addr, exp.mem_addr);
                check_value("data_wstrb", 32'(data_wstrb), 32'(exp.wstrb));
                if (data_wr) check_value("data_wdata", data_wdata, exp.wdata);
            end
        end
    endtask

    // handshakes are stable mid cycle, transfers happen on the next edge
    always @(negedge clk) begin
        if (reset) begin
            in_fire = 1'b0;
        end else begin
            in_fire = in_valid && in_ready;
            if (data_req && !out_ready)
                stop_with_error("data_req was high while out_ready was low");
            if (data_req && data_addr_ok) begin
                mem_accepts++;
                if (!(out_valid && out_ready))
                    stop_with_error("memory request accepted without its item leaving");
            end
            if (in_fire) begin
                model_accept(in_op);
                sent++;
            end
            if (out_valid && out_ready) begin
                compare_output();
                received++;
            end
        end
    end

    initial begin
        #(num_items * cycles_per_item * 4);
        $display("watchdog expired before all items left the DUT");
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        int unsigned seed_ret;
        seed_ret = $urandom(55023);
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = '0;
        out_ready = 1'b0;
        data_addr_ok = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        check_value("in_ready after reset", 32'(in_ready), 32'd1);
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        check_value("data_req after reset", 32'(data_req), 32'd0);
        while (received < num_items) begin
            @(posedge clk);
            #1;
            drive_inputs();
        end
        if (expected_q.size() == 0 && mem_accepts == mem_expected) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("items or memory requests were left unmatched at the end of the run");
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

/* exe_top.f */
+incdir+verif
common/exe_pkg.sv
design/stage_reg.sv
alu/exe_alu.sv
design/hilo_unit.sv
design/mem_req_gen.sv
design/exe_top.sv
verif/exe_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f exe_top.f --top-module exe_tb -Mdir obj_dir -o exe_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/exe_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation completed"
exit 0
